// ==== build.f ====
hw/pifPkg.sv
hw/efbWbMaster.sv
hw/pifSequencer.sv
hw/xiRegPort.sv
hw/pifBridge.sv
bench/efbModel.sv
bench/pifBridge_properties.sv
bench/tbPifBridge.sv

// ==== Makefile ====
# Verilator flow for the I2C register bridge

VERILATOR ?= verilator
TOP       ?= tbPifBridge
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= build.f
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/tbPifBridge.sv ====
`timescale 1ns/1ps

module tbPifBridge
    import pifPkg::*;
();

    localparam int NEV     = 20;
    localparam int TIMEOUT = 20000;

    localparam logic [1:0] EV_NOTBUSY = 2'd0;
    localparam logic [1:0] EV_RX      = 2'd1;
    localparam logic [1:0] EV_TX      = 2'd2;
    localparam logic [1:0] EV_NAK     = 2'd3;

    // kind 1 is a pWr, kind 2 a read-finished
    typedef struct packed {
        logic [1:0]       kind;
        logic [TXA_W-1:0] addr;
        logic [2:0]       subA;
        logic [7:0]       val;
    } expEv_t;

    logic       xclk;
    logic       sys_rst;
    logic       efbAck;
    logic [7:0] efbDat;
    logic [7:0] xo;
    wbBus_t     wb;
    xiPort_t    xi;
    logic       scriptDone;
    logic [1:0] evKind [NEV];
    logic [7:0] evByte [NEV];
    expEv_t     expQ[$];
    int         initPhase;
    int         opCount;
    int         initCount;
    int         initsExp;
    logic       srBusy;

    pifBridge #(.subAMax(XSUBA_MAX)) u_pifBridge (
        .xclk     (xclk),
        .sys_rst  (sys_rst),
        .efbAck_i (efbAck),
        .efbDat_i (efbDat),
        .xo_i     (xo),
        .wb_o     (wb),
        .xi_o     (xi)
    );

    efbModel #(.nEv(NEV)) u_efbModel (
        .xclk         (xclk),
        .sys_rst      (sys_rst),
        .wb_i         (wb),
        .evKind_i     (evKind),
        .evByte_i     (evByte),
        .efbAck_o     (efbAck),
        .efbDat_o     (efbDat),
        .scriptDone_o (scriptDone)
    );

    initial begin
        xclk = 1'b0;
        forever #50 xclk = ~xclk;
    end

    task reportMismatch(input string name, input int expVal, input int actVal);
        $display("Fail %s: expected %0h, actual %0h", name, expVal, actVal);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task reportError(input string msg);
        $display("Error: %s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    // byte the register file would return for an address and sub-address
    function automatic logic [7:0] xoFor(input logic [TXA_W-1:0] addr, input logic [2:0] subA);
        xoFor = {addr[4:0], subA} ^ 8'hA5;
    endfunction

    // ------------------------------
    // reference model
    // ------------------------------
    function automatic expEv_t refEvent(input int idx);
        logic [TXA_W-1:0] addr;
        logic [2:0]       subA;
        expEv_t           ev;
        addr = '0;
        subA = '0;
        for (int j = 0; j < idx; j++) begin
            if (evKind[j] == EV_RX && evByte[j][7:6] == TAG_ADDR) begin
                addr = evByte[j][5:0];
                subA = '0;
            end else if (evKind[j] == EV_TX) begin
                subA = (subA == 3'(XSUBA_MAX)) ? 3'd0 : subA + 3'd1;
            end
        end
        ev = '{kind: 2'd0, addr: addr, subA: subA, val: 8'h00};
        if (evKind[idx] == EV_RX && evByte[idx][7:6] == TAG_DATA) begin
            ev.kind = 2'd1;
            ev.val  = {2'b00, evByte[idx][5:0]};
        end else if (evKind[idx] == EV_TX) begin
            ev.kind = 2'd2;
            ev.val  = xoFor(addr, subA);
        end
        refEvent = ev;
    endfunction

    task setEvent(input int i, input logic [1:0] kind, input logic [7:0] byteVal);
        evKind[i] = kind;
        evByte[i] = byteVal;
    endtask

    // address, data, two ignored tags, data, nine reads with a wrap,
    // NAK, data, read, drop to not-busy, new address, read
    task loadScript;
        setEvent(0, EV_RX, 8'h4A);
        setEvent(1, EV_RX, 8'h85);
        setEvent(2, EV_RX, 8'hC3);
        setEvent(3, EV_RX, 8'h3F);
        setEvent(4, EV_RX, 8'hAA);
        for (int i = 5; i < 14; i++) begin
            setEvent(i, EV_TX, 8'h00);
        end
        setEvent(14, EV_NAK, 8'h00);
        setEvent(15, EV_RX, 8'h9C);
        setEvent(16, EV_TX, 8'h00);
        setEvent(17, EV_NOTBUSY, 8'h00);
        setEvent(18, EV_RX, 8'h55);
        setEvent(19, EV_TX, 8'h00);
    endtask

    always @(posedge xclk) begin
        #1;
        xo <= xoFor(xi.prwa, xi.prdSubA);
    end

    // init order after every stretch-disable write
    task checkInitOp;
        logic       isCksDis;
        logic       isSrRd;
        logic       isRxRd;
        efbStatus_t srVal;
        isCksDis = wb.we && wb.adr == I2C1_CMDR && wb.datW == CMD_CKSDIS;
        isSrRd   = !wb.we && wb.adr == I2C1_SR;
        isRxRd   = !wb.we && wb.adr == I2C1_RXDR;
        srVal    = efbStatus_t'(efbDat);
        if (opCount == 0) begin
            assert (isCksDis) else reportError("first bus operation is not the CMDR init write");
        end
        case (initPhase)
            0: if (isCksDis) initPhase = 1;
            1: begin
                assert (isSrRd) else reportError("no SR poll after the CMDR init write");
                srBusy    = srVal.busy;
                initPhase = 2;
            end
            // polling goes on exactly while SR reads busy
            2: begin
                if (isRxRd) begin
                    assert (!srBusy) else reportError("RXDR flush read while SR still busy");
                    initPhase = 3;
                end else begin
                    assert (isSrRd && srBusy)
                    else reportError("unexpected bus operation while polling SR");
                    srBusy = srVal.busy;
                end
            end
            3: begin
                assert (isRxRd) else reportError("second RXDR flush read missing");
                initPhase = 4;
            end
            default: begin
                assert (wb.we && wb.adr == I2C1_CMDR && wb.datW == CMD_CKSEN)
                else reportError("init did not end with the stretch-enable CMDR write");
                initPhase = 0;
                initCount++;
            end
        endcase
    endtask

    // ------------------------------
    // comparison
    // ------------------------------
    always @(posedge xclk) begin
        if (sys_rst) begin
            if (wb.cyc && efbAck) begin
                checkInitOp();
                if (wb.we && wb.adr == I2C1_TXDR) begin
                    assert (expQ.size() > 0 && expQ[0].kind == 2'd2)
                    else reportError("TXDR write without a pending transmit request");
                    assert (wb.datW == expQ[0].val)
                    else reportMismatch("TXDR data", expQ[0].val, wb.datW);
                end
                opCount++;
            end
            if (xi.pWr) begin
                assert (initPhase == 0) else reportError("pWr strobe during EFB init");
                assert (expQ.size() > 0 && expQ[0].kind == 2'd1)
                else reportError("pWr strobe that no data byte asked for");
                assert (xi.pd == expQ[0].val[5:0])
                else reportMismatch("pWr data", expQ[0].val, xi.pd);
                void'(expQ.pop_front());
            end
            if (xi.prdFinished) begin
                assert (expQ.size() > 0 && expQ[0].kind == 2'd2)
                else reportError("prdFinished strobe that no transmit asked for");
                assert (xi.prwa == expQ[0].addr)
                else reportMismatch("read address", expQ[0].addr, xi.prwa);
                assert (xi.prdSubA == expQ[0].subA)
                else reportMismatch("read sub-address", expQ[0].subA, xi.prdSubA);
                void'(expQ.pop_front());
            end
        end
    end

    initial begin
        int cycles;
        sys_rst   = 1'b0;
        xo        = 8'h00;
        initPhase = 0;
        opCount   = 0;
        initCount = 0;
        srBusy    = 1'b0;
        loadScript();
        // one init after reset, one per NAK or not-busy event, one when the script runs out
        initsExp = 2;
        for (int i = 0; i < NEV; i++) begin
            if (refEvent(i).kind != 2'd0) begin
                expQ.push_back(refEvent(i));
            end
            if (evKind[i] == EV_NAK || evKind[i] == EV_NOTBUSY) begin
                initsExp++;
            end
        end
        repeat (16) @(posedge xclk);
        #1;
        sys_rst = 1'b1;
        assert (!wb.cyc && !wb.stb && !xi.pWr && !xi.prdFinished)
        else reportError("outputs not idle after reset");
        cycles = 0;
        while (!(scriptDone && expQ.size() == 0)) begin
            @(posedge xclk);
            cycles++;
            if (cycles > TIMEOUT) begin
                reportError("timed out before the script finished");
            end
        end
        // trailing restart once the bus goes quiet
        cycles = 0;
        while (initCount < initsExp) begin
            @(posedge xclk);
            cycles++;
            if (cycles > TIMEOUT) begin
                reportError("timed out waiting for the final EFB init");
            end
        end
        if (initCount == initsExp) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            reportError("more EFB init sequences than the script asks for");
        end
    end

endmodule

// ==== bench/pifBridge_properties.sv ====
`timescale 1ns/1ps

module pifBridge_properties
    import pifPkg::*;
(
    input logic   xclk,
    input logic   sys_rst,
    input logic   reqStart_i,
    input wbBus_t wb_o,
    input logic   efbAck_i,
    input logic   reqDone_o
);

    // cyc and stb come up together the cycle after a request
    cycStart: assert property (@(posedge xclk) disable iff (!sys_rst)
        (reqStart_i && !wb_o.cyc) |=> (wb_o.cyc && wb_o.stb))
    else $error("wishbone cyc and stb did not rise together after reqStart");

    // request held until acknowledged
    reqStable: assert property (@(posedge xclk) disable iff (!sys_rst)
        (wb_o.stb && !efbAck_i) |=> ($stable(wb_o.adr) && $stable(wb_o.datW) && $stable(wb_o.we)))
    else $error("wishbone request changed while waiting for ack");

    cycEnds: assert property (@(posedge xclk) disable iff (!sys_rst)
        (wb_o.cyc && efbAck_i) |=> (!wb_o.cyc && reqDone_o))
    else $error("wishbone cyc still high or reqDone missing the cycle after ack");

endmodule

bind efbWbMaster pifBridge_properties u_wbProps (.*);

// ==== bench/efbModel.sv ====
`timescale 1ns/1ps

module efbModel
    import pifPkg::*;
#(
    parameter int nEv = 20
) (
    input  logic       xclk,
    input  logic       sys_rst,
    input  wbBus_t     wb_i,
    input  logic [1:0] evKind_i [nEv],
    input  logic [7:0] evByte_i [nEv],
    output logic       efbAck_o,
    output logic [7:0] efbDat_o,
    output logic       scriptDone_o
);

    // script event kinds
    localparam logic [1:0] EV_NOTBUSY = 2'd0;
    localparam logic [1:0] EV_RX      = 2'd1;
    localparam logic [1:0] EV_TX      = 2'd2;
    localparam logic [1:0] EV_NAK     = 2'd3;

    int          idx;
    logic        inInit;
    int          initBusy;
    integer      seed;
    logic [31:0] rnd;
    int          waits;

    assign scriptDone_o = (idx == nEv);

    // SR value for the current script event
    function automatic logic [7:0] statusFor(input logic [1:0] kind);
        case (kind)
            EV_RX:   statusFor = 8'h44;
            EV_TX:   statusFor = 8'h54;
            EV_NAK:  statusFor = 8'h72;
            default: statusFor = 8'h00;
        endcase
    endfunction

    // ------------------------------
    // register access
    // ------------------------------
    task serveAccess;
        logic [1:0] kind;
        kind     = (idx < nEv) ? evKind_i[idx] : EV_NOTBUSY;
        efbDat_o = 8'h00;
        if (wb_i.we) begin
            $display("efb write %02h <= %02h", wb_i.adr, wb_i.datW);
            if (wb_i.adr == I2C1_CMDR && wb_i.datW == CMD_CKSDIS) begin
                // restart, SR reads busy twice before settling
                inInit   = 1'b1;
                initBusy = 2;
                if (idx < nEv && (kind == EV_NAK || kind == EV_NOTBUSY)) begin
                    idx++;
                end
            end else if (wb_i.adr == I2C1_CMDR && wb_i.datW == CMD_CKSEN) begin
                inInit = 1'b0;
            end else if (wb_i.adr == I2C1_TXDR && idx < nEv && kind == EV_TX) begin
                idx++;
            end
        end else if (wb_i.adr == I2C1_SR) begin
            if (inInit) begin
                efbDat_o = (initBusy > 0) ? 8'h40 : 8'h00;
                if (initBusy > 0) begin
                    initBusy--;
                end
            end else begin
                efbDat_o = statusFor(kind);
            end
        end else if (wb_i.adr == I2C1_RXDR) begin
            // stale byte during init, tagged as an address on purpose
            if (inInit) begin
                efbDat_o = 8'h55;
            end else if (idx < nEv && kind == EV_RX) begin
                efbDat_o = evByte_i[idx];
                idx++;
            end
        end
    endtask

    initial begin
        seed     = 32'h7136_97cb;
        idx      = 0;
        inInit   = 1'b0;
        initBusy = 0;
        efbAck_o = 1'b0;
        efbDat_o = 8'h00;
        forever begin
            @(posedge xclk);
            if (sys_rst && wb_i.cyc && wb_i.stb) begin
                rnd   = $random(seed);
                waits = int'(rnd[1:0]);
                repeat (waits) @(posedge xclk);
                #1;
                serveAccess();
                efbAck_o = 1'b1;
                @(posedge xclk);
                #1;
                efbAck_o = 1'b0;
            end
        end
    end

endmodule

// ==== hw/pifBridge.sv ====
`timescale 1ns/1ps

module pifBridge
    import pifPkg::*;
#(
    parameter int subAMax = XSUBA_MAX
) (
    input  logic       xclk,
    input  logic       sys_rst,
    input  logic       efbAck_i,
    input  logic [7:0] efbDat_i,
    input  logic [7:0] xo_i,
    output wbBus_t     wb_o,
    output xiPort_t    xi_o
);

    localparam int subAW = $clog2(subAMax + 1);

    // sequencer to bus master
    logic       reqStart;
    wbReq_t     wbReq;
    logic       reqDone;
    logic [7:0] rdData;

    // sequencer to register port
    logic       rxStrobe;
    logic [7:0] rxByte;
    logic       txDone;

    pifSequencer u_pifSequencer (
        .xclk       (xclk),
        .sys_rst    (sys_rst),
        .reqDone_i  (reqDone),
        .rdData_i   (rdData),
        .xo_i       (xo_i),
        .reqStart_o (reqStart),
        .req_o      (wbReq),
        .rxStrobe_o (rxStrobe),
        .rxByte_o   (rxByte),
        .txDone_o   (txDone)
    );

    efbWbMaster u_efbWbMaster (
        .xclk       (xclk),
        .sys_rst    (sys_rst),
        .reqStart_i (reqStart),
        .req_i      (wbReq),
        .efbAck_i   (efbAck_i),
        .efbDat_i   (efbDat_i),
        .wb_o       (wb_o),
        .reqDone_o  (reqDone),
        .rdData_o   (rdData)
    );

    xiRegPort #(
        .subAMax (subAMax),
        .subAW   (subAW)
    ) u_xiRegPort (
        .xclk       (xclk),
        .sys_rst    (sys_rst),
        .rxStrobe_i (rxStrobe),
        .rxByte_i   (rxByte),
        .txDone_i   (txDone),
        .xi_o       (xi_o)
    );

endmodule

// ==== hw/xiRegPort.sv ====
`timescale 1ns/1ps

module xiRegPort
    import pifPkg::*;
#(
    parameter int subAMax = XSUBA_MAX,
    parameter int subAW   = SUBA_W
) (
    input  logic       xclk,
    input  logic       sys_rst,
    input  logic       rxStrobe_i,
    input  logic [7:0] rxByte_i,
    input  logic       txDone_i,
    output xiPort_t    xi_o
);

    logic [1:0]               tag;
    logic [I2C_DATA_BITS-1:0] payload;
    logic                     isAddr;
    logic                     isData;

    logic                     pWr;
    logic                     prdFinished;
    logic [TXA_W-1:0]         rwAddr;
    logic [I2C_DATA_BITS-1:0] pd;
    logic [subAW-1:0]         rdSubA;

    // tag in the top bits, other tags fall through
    assign tag     = rxByte_i[7 -: 2];
    assign payload = rxByte_i[I2C_DATA_BITS-1:0];
    assign isAddr  = rxStrobe_i && (tag == TAG_ADDR);
    assign isData  = rxStrobe_i && (tag == TAG_DATA);

    // ------------------------------
    // address and sub-address
    // ------------------------------
    always_ff @(posedge xclk or negedge sys_rst) begin
        if (!sys_rst) begin
            rwAddr      <= '0;
            rdSubA      <= '0;
            pWr         <= 1'b0;
            prdFinished <= 1'b0;
        end else begin
            pWr         <= isData;
            prdFinished <= txDone_i;
            if (isAddr) begin
                rwAddr <= payload[TXA_W-1:0];
            end
            // new address restarts the read counter
            if (isAddr) begin
                rdSubA <= '0;
            end else if (prdFinished) begin
                rdSubA <= (rdSubA == subAW'(subAMax)) ? '0 : rdSubA + 1'b1;
            end
        end
    end

    // write data, valid from the pWr cycle on
    always_ff @(posedge xclk) begin
        if (isData) begin
            pd <= payload;
        end
    end

    assign xi_o = '{
        pWr:         pWr,
        prwa:        rwAddr,
        prdFinished: prdFinished,
        prdSubA:     SUBA_W'(rdSubA),
        pd:          pd
    };

endmodule

// ==== hw/pifSequencer.sv ====
`timescale 1ns/1ps

module pifSequencer
    import pifPkg::*;
(
    input  logic       xclk,
    input  logic       sys_rst,
    input  logic       reqDone_i,
    input  logic [7:0] rdData_i,
    input  logic [7:0] xo_i,
    output logic       reqStart_o,
    output wbReq_t     req_o,
    output logic       rxStrobe_o,
    output logic [7:0] rxByte_o,
    output logic       txDone_o
);

    seqState_t  state;
    seqState_t  stateN;
    seqState_t  retState;
    seqState_t  retN;
    logic       doReq;
    wbReq_t     reqN;
    efbStatus_t sr;
    logic       srRead;

    // decoded SR flags, from the latest status read
    logic busy;
    logic txReady;
    logic rxReady;
    logic lastTxNak;

    function automatic wbReq_t rdReq(input logic [7:0] addr);
        rdReq = '{addr: addr, wdata: 8'h00, we: 1'b0};
    endfunction

    function automatic wbReq_t wrReq(input logic [7:0] addr, input logic [7:0] data);
        wrReq = '{addr: addr, wdata: data, we: 1'b1};
    endfunction

    assign sr     = efbStatus_t'(rdData_i);
    assign srRead = !req_o.we && (req_o.addr == I2C1_SR);

    // ------------------------------
    // next state and bus request
    // ------------------------------
    always_comb begin
        doReq  = 1'b0;
        reqN   = rdReq(I2C1_SR);
        retN   = retState;
        stateN = state;
        case (state)
            // init with clock stretching off
            sStart: begin
                doReq = 1'b1;
                reqN  = wrReq(I2C1_CMDR, CMD_CKSDIS);
                retN  = sInit1;
            end
            sInit1: begin
                doReq = 1'b1;
                retN  = sInit2;
            end
            // keep polling SR until the slave is quiet
            sInit2: begin
                doReq = 1'b1;
                if (!busy) begin
                    reqN = rdReq(I2C1_RXDR);
                    retN = sInit3;
                end else begin
                    retN = sInit2;
                end
            end
            sInit3: begin
                doReq = 1'b1;
                reqN  = rdReq(I2C1_RXDR);
                retN  = sInit4;
            end
            sInit4: begin
                doReq = 1'b1;
                reqN  = wrReq(I2C1_CMDR, CMD_CKSEN);
                retN  = sIdle;
            end
            sIdle: begin
                doReq = 1'b1;
                retN  = busy ? sWaitTR : sIdle;
            end
            // NAK wins over everything else
            sWaitTR: begin
                if (lastTxNak) begin
                    stateN = sStart;
                end else if (txReady) begin
                    doReq = 1'b1;
                    reqN  = wrReq(I2C1_TXDR, xo_i);
                    retN  = sOut0;
                end else if (rxReady) begin
                    doReq = 1'b1;
                    reqN  = rdReq(I2C1_RXDR);
                    retN  = sIn0;
                end else if (!busy) begin
                    stateN = sStart;
                end else begin
                    doReq = 1'b1;
                    retN  = sWaitTR;
                end
            end
            sIn0:  stateN = sIdle;
            sOut0: stateN = sOut1;
            sOut1: stateN = sIdle;
            sBusCycle: begin
                if (reqDone_i) begin
                    stateN = retState;
                end
            end
            default: stateN = sStart;
        endcase
        if (doReq) begin
            stateN = sBusCycle;
        end
    end

    // ------------------------------
    // registers
    // ------------------------------
    always_ff @(posedge xclk or negedge sys_rst) begin
        if (!sys_rst) begin
            state      <= sStart;
            retState   <= sStart;
            reqStart_o <= 1'b0;
            rxStrobe_o <= 1'b0;
            txDone_o   <= 1'b0;
            busy       <= 1'b0;
            txReady    <= 1'b0;
            rxReady    <= 1'b0;
            lastTxNak  <= 1'b0;
        end else begin
            state      <= stateN;
            reqStart_o <= doReq;
            if (doReq) begin
                retState <= retN;
            end
            rxStrobe_o <= 1'b0;
            txDone_o   <= 1'b0;
            if (state == sBusCycle && reqDone_i) begin
                // strobes line up with sIn0 / sOut0
                rxStrobe_o <= (retState == sIn0);
                txDone_o   <= (retState == sOut0);
                if (srRead) begin
                    busy      <= sr.busy;
                    txReady   <= sr.busy & sr.trrdy & sr.srw & !sr.tip;
                    rxReady   <= sr.busy & sr.trrdy & !sr.srw;
                    lastTxNak <= sr.busy & sr.rarc & sr.srw & sr.troe;
                end
            end
        end
    end

    // payload, no reset needed
    always_ff @(posedge xclk) begin
        if (doReq) begin
            req_o <= reqN;
        end
        if (state == sBusCycle && reqDone_i) begin
            rxByte_o <= rdData_i;
        end
    end

endmodule

// ==== hw/efbWbMaster.sv ====
`timescale 1ns/1ps

module efbWbMaster
    import pifPkg::*;
(
    input  logic       xclk,
    input  logic       sys_rst,
    input  logic       reqStart_i,
    input  wbReq_t     req_i,
    input  logic       efbAck_i,
    input  logic [7:0] efbDat_i,
    output wbBus_t     wb_o,
    output logic       reqDone_o,
    output logic [7:0] rdData_o
);

    wbReq_t reqQ;
    logic   active;

    // ------------------------------
    // cycle control
    // ------------------------------
    // cyc/stb rise the cycle after reqStart and drop the cycle after ack
    always_ff @(posedge xclk or negedge sys_rst) begin
        if (!sys_rst) begin
            active    <= 1'b0;
            reqDone_o <= 1'b0;
        end else begin
            reqDone_o <= 1'b0;
            if (!active) begin
                if (reqStart_i) begin
                    active <= 1'b1;
                end
            end else if (efbAck_i) begin
                active    <= 1'b0;
                reqDone_o <= 1'b1;
            end
        end
    end

    // request latch, held steady for the whole cycle
    always_ff @(posedge xclk) begin
        if (reqStart_i && !active) begin
            reqQ <= req_i;
        end
        // read data sampled together with ack
        if (active && efbAck_i) begin
            rdData_o <= efbDat_i;
        end
    end

    assign wb_o = '{
        cyc:  active,
        stb:  active,
        we:   active & reqQ.we,
        adr:  reqQ.addr,
        datW: reqQ.wdata
    };

endmodule

// ==== hw/pifPkg.sv ====
package pifPkg;

    // ------------------------------
    // EFB register map, primary I2C
    // ------------------------------
    localparam logic [7:0] I2C1_CR   = 8'h40;
    localparam logic [7:0] I2C1_CMDR = 8'h41;
    localparam logic [7:0] I2C1_TXDR = 8'h44;
    localparam logic [7:0] I2C1_SR   = 8'h45;
    localparam logic [7:0] I2C1_RXDR = 8'h47;

    // CMDR values, bit 2 is CKSDIS
    localparam logic [7:0] CMD_CKSDIS = 8'h04;
    localparam logic [7:0] CMD_CKSEN  = 8'h00;

    // ------------------------------
    // received byte layout
    // ------------------------------
    // top two bits are the tag, the rest is payload
    localparam int I2C_DATA_BITS = 6;
    localparam logic [1:0] TAG_ADDR = 2'd1;
    localparam logic [1:0] TAG_DATA = 2'd2;

    // register address is the whole payload
    localparam int TXA_W = 6;

    // sub-addresses count 0..XSUBA_MAX, then wrap
    localparam int XSUBA_MAX = 7;
    localparam int SUBA_W    = 3;

    // SR bits, msb first
    typedef struct packed {
        logic tip;
        logic busy;
        logic rarc;
        logic srw;
        logic arbl;
        logic trrdy;
        logic troe;
        logic hgc;
    } efbStatus_t;

    // one bus operation asked for by the sequencer
    typedef struct packed {
        logic [7:0] addr;
        logic [7:0] wdata;
        logic       we;
    } wbReq_t;

    // wishbone outputs towards the EFB
    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        logic [7:0] adr;
        logic [7:0] datW;
    } wbBus_t;

    // parallel register port
    typedef struct packed {
        logic                     pWr;
        logic [TXA_W-1:0]         prwa;
        logic                     prdFinished;
        logic [SUBA_W-1:0]        prdSubA;
        logic [I2C_DATA_BITS-1:0] pd;
    } xiPort_t;

    typedef enum logic [3:0] {
        sStart,
        sInit1,
        sInit2,
        sInit3,
        sInit4,
        sIdle,
        sWaitTR,
        sIn0,
        sOut0,
        sOut1,
        sBusCycle
    } seqState_t;

endpackage
